/* src/rob_pkg.sv */
package rob_pkg;

    ////////////////////
    // buffer geometry
    ////////////////////

    // index width, entry count follows from it
    localparam int ROB_WIDTH = 4;
    localparam int ROB_DEPTH = 1 << ROB_WIDTH;

    // occupancy counter needs one extra bit to tell full from empty
    localparam int CNT_W = ROB_WIDTH + 1;

    // dispatch takes two entries, so stop once fewer than two are free
    localparam logic [CNT_W-1:0] READY_MAX_CNT = CNT_W'(ROB_DEPTH - 2);

    ////////////////////
    // field widths
    ////////////////////

    // result data
    localparam int DATA_W = 32;

    // architectural register index
    localparam int AREG_W = 5;

    // program counter
    localparam int PC_W = 32;

    // exception code, zero means no exception
    localparam int EXC_W = 6;

    ////////////////////
    // instruction type
    ////////////////////

    typedef enum logic [1:0] {
        INST_ALU    = 2'd0,
        INST_MDU    = 2'd1,
        INST_LSU    = 2'd2,
        INST_BRANCH = 2'd3
    } rob_inst_type_e;

endpackage

/* src/rob_info_table.sv */
`timescale 1ns/10ps

module rob_info_table import rob_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic           [ROB_WIDTH-1:0]      head_i,
    input  logic           [ROB_WIDTH-1:0]      tail_i,
    input  logic           [1:0]                dispatch_valid_i,
    input  logic           [1:0][AREG_W-1:0]    dispatch_areg_i,
    input  logic           [1:0][PC_W-1:0]      dispatch_pc_i,
    input  rob_inst_type_e [1:0]                dispatch_type_i,
    input  logic           [1:0]                dispatch_wreg_i,
    output logic           [1:0][AREG_W-1:0]    commit_areg_o,
    output logic           [1:0][PC_W-1:0]      commit_pc_o,
    output rob_inst_type_e [1:0]                commit_type_o,
    output logic           [1:0]                commit_wreg_o
);

    // write slots sit at head and head+1 and read slots at tail and tail+1
    logic [1:0][ROB_WIDTH-1:0] wr_idx;
    logic [1:0][ROB_WIDTH-1:0] rd_idx;

    // instruction fields fixed at dispatch
    logic [AREG_W-1:0]  areg_mem [ROB_DEPTH];
    logic [PC_W-1:0]    pc_mem   [ROB_DEPTH];
    rob_inst_type_e     type_mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] wreg_q;

    assign wr_idx[0] = head_i;
    assign wr_idx[1] = head_i + ROB_WIDTH'(1);
    assign rd_idx[0] = tail_i;
    assign rd_idx[1] = tail_i + ROB_WIDTH'(1);

    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (dispatch_valid_i[k]) begin
                areg_mem[wr_idx[k]] <= dispatch_areg_i[k];
                pc_mem[wr_idx[k]]   <= dispatch_pc_i[k];
                type_mem[wr_idx[k]] <= dispatch_type_i[k];
            end
        end
    end

    // write-register flag per entry
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wreg_q <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (dispatch_valid_i[k]) begin
                    wreg_q[wr_idx[k]] <= dispatch_wreg_i[k];
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            commit_areg_o[k] = areg_mem[rd_idx[k]];
            commit_pc_o[k]   = pc_mem[rd_idx[k]];
            commit_type_o[k] = type_mem[rd_idx[k]];
            commit_wreg_o[k] = wreg_q[rd_idx[k]];
        end
    end

endmodule

/* src/rob_result_table.sv */
`timescale 1ns/10ps

module rob_result_table import rob_pkg::*; (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic [ROB_WIDTH-1:0]            head_i,
    input  logic [ROB_WIDTH-1:0]            tail_i,
    input  logic [1:0]                      dispatch_valid_i,
    input  logic [1:0]                      cdb_valid_i,
    input  logic [1:0][ROB_WIDTH-1:0]       cdb_rob_id_i,
    input  logic [1:0][DATA_W-1:0]          cdb_data_i,
    input  logic [1:0][EXC_W-1:0]           cdb_exc_i,
    input  logic [1:0][ROB_WIDTH-1:0]       src_id_i,
    output logic [1:0]                      slot_complete_o,
    output logic [1:0][DATA_W-1:0]          commit_data_o,
    output logic [1:0][EXC_W-1:0]           commit_exc_o,
    output logic [1:0][DATA_W-1:0]          src_data_o,
    output logic [1:0]                      src_complete_o
);

    logic [1:0][ROB_WIDTH-1:0] wr_idx;
    logic [1:0][ROB_WIDTH-1:0] rd_idx;

    ////////////////////
    // completion tables
    ////////////////////

    // entry is complete while the two bits differ
    logic [ROB_DEPTH-1:0] disp_bit;
    logic [ROB_DEPTH-1:0] cdb_bit;

    assign wr_idx[0] = head_i;
    assign wr_idx[1] = head_i + ROB_WIDTH'(1);
    assign rd_idx[0] = tail_i;
    assign rd_idx[1] = tail_i + ROB_WIDTH'(1);

    // dispatch side copies the cdb bit, entry becomes pending
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (dispatch_valid_i[k]) begin
                disp_bit[wr_idx[k]] <= cdb_bit[wr_idx[k]];
            end
        end
    end

    // cdb side stores the inverse, entry becomes complete
    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (cdb_valid_i[k]) begin
                cdb_bit[cdb_rob_id_i[k]] <= ~disp_bit[cdb_rob_id_i[k]];
            end
        end
    end

    ////////////////////
    // result payload
    ////////////////////

    logic [DATA_W-1:0]               data_mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0][EXC_W-1:0] exc_q;

    always_ff @(posedge clk) begin
        for (int k = 0; k < 2; k++) begin
            if (cdb_valid_i[k]) begin
                data_mem[cdb_rob_id_i[k]] <= cdb_data_i[k];
            end
        end
    end

    // exception codes start at "none"
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exc_q <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (cdb_valid_i[k]) begin
                    exc_q[cdb_rob_id_i[k]] <= cdb_exc_i[k];
                end
            end
        end
    end

    // commit slots and source ports, no bypass from this cycle's cdb
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            slot_complete_o[k] = disp_bit[rd_idx[k]] ^ cdb_bit[rd_idx[k]];
            commit_data_o[k]   = data_mem[rd_idx[k]];
            commit_exc_o[k]    = exc_q[rd_idx[k]];
            src_complete_o[k]  = disp_bit[src_id_i[k]] ^ cdb_bit[src_id_i[k]];
            src_data_o[k]      = data_mem[src_id_i[k]];
        end
    end

endmodule

/* src/rob_commit_ctrl.sv */
`timescale 1ns/10ps

module rob_commit_ctrl import rob_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic [1:0]              dispatch_valid_i,
    input  logic [1:0]              commit_req_i,
    input  logic [1:0]              slot_complete_i,
    output logic [ROB_WIDTH-1:0]    head_o,
    output logic [ROB_WIDTH-1:0]    tail_o,
    output logic                    dispatch_ready_o,
    output logic [1:0]              commit_valid_o
);

    // head is the next free entry, tail the oldest live one
    logic [ROB_WIDTH-1:0] head_q;
    logic [ROB_WIDTH-1:0] tail_q;
    logic [CNT_W-1:0]     count_q;

    // entries taken and released this cycle
    logic [1:0] n_disp;
    logic [1:0] n_commit;

    logic slot0_valid;
    logic slot1_valid;

    assign n_disp   = {1'b0, dispatch_valid_i[0]} + {1'b0, dispatch_valid_i[1]};
    assign n_commit = {1'b0, commit_req_i[0]} + {1'b0, commit_req_i[1]};

    ////////////////////
    // pointers and count
    ////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // flush drops everything in flight
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + ROB_WIDTH'(n_disp);
            tail_q  <= tail_q + ROB_WIDTH'(n_commit);
            count_q <= count_q + CNT_W'(n_disp) - CNT_W'(n_commit);
        end
    end

    ////////////////////
    // commit valid
    ////////////////////

    // in order, slot 1 only behind a valid slot 0
    assign slot0_valid = (|count_q) & slot_complete_i[0];
    assign slot1_valid = slot0_valid & (|count_q[CNT_W-1:1]) & slot_complete_i[1];

    assign commit_valid_o   = {slot1_valid, slot0_valid};
    assign dispatch_ready_o = (count_q <= READY_MAX_CNT);

    assign head_o = head_q;
    assign tail_o = tail_q;

endmodule

/* src/rob_top.sv */
`timescale 1ns/10ps

module rob_top import rob_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,

    // dispatch
    input  logic           [1:0]                dispatch_valid_i,
    input  logic           [1:0][AREG_W-1:0]    dispatch_areg_i,
    input  logic           [1:0][PC_W-1:0]      dispatch_pc_i,
    input  rob_inst_type_e [1:0]                dispatch_type_i,
    input  logic           [1:0]                dispatch_wreg_i,
    output logic           [1:0][ROB_WIDTH-1:0] dispatch_rob_id_o,
    output logic                                dispatch_ready_o,

    // source operand lookup
    input  logic           [1:0][ROB_WIDTH-1:0] src_id_i,
    output logic           [1:0][DATA_W-1:0]    src_data_o,
    output logic           [1:0]                src_complete_o,

    // result bus
    input  logic           [1:0]                cdb_valid_i,
    input  logic           [1:0][ROB_WIDTH-1:0] cdb_rob_id_i,
    input  logic           [1:0][DATA_W-1:0]    cdb_data_i,
    input  logic           [1:0][EXC_W-1:0]     cdb_exc_i,

    // commit
    input  logic           [1:0]                commit_req_i,
    output logic           [1:0]                commit_valid_o,
    output logic           [1:0][AREG_W-1:0]    commit_areg_o,
    output logic           [1:0][PC_W-1:0]      commit_pc_o,
    output rob_inst_type_e [1:0]                commit_type_o,
    output logic           [1:0]                commit_wreg_o,
    output logic           [1:0][DATA_W-1:0]    commit_data_o,
    output logic           [1:0][EXC_W-1:0]     commit_exc_o
);

    logic [ROB_WIDTH-1:0] head;
    logic [ROB_WIDTH-1:0] tail;
    logic [1:0]           slot_complete;

    // ids handed back to dispatch
    assign dispatch_rob_id_o[0] = head;
    assign dispatch_rob_id_o[1] = head + ROB_WIDTH'(1);

    rob_commit_ctrl u_commit_ctrl (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .commit_req_i     (commit_req_i),
        .slot_complete_i  (slot_complete),
        .head_o           (head),
        .tail_o           (tail),
        .dispatch_ready_o (dispatch_ready_o),
        .commit_valid_o   (commit_valid_o)
    );

    rob_info_table u_info_table (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .head_i           (head),
        .tail_i           (tail),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_areg_i  (dispatch_areg_i),
        .dispatch_pc_i    (dispatch_pc_i),
        .dispatch_type_i  (dispatch_type_i),
        .dispatch_wreg_i  (dispatch_wreg_i),
        .commit_areg_o    (commit_areg_o),
        .commit_pc_o      (commit_pc_o),
        .commit_type_o    (commit_type_o),
        .commit_wreg_o    (commit_wreg_o)
    );

    rob_result_table u_result_table (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .head_i           (head),
        .tail_i           (tail),
        .dispatch_valid_i (dispatch_valid_i),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_rob_id_i     (cdb_rob_id_i),
        .cdb_data_i       (cdb_data_i),
        .cdb_exc_i        (cdb_exc_i),
        .src_id_i         (src_id_i),
        .slot_complete_o  (slot_complete),
        .commit_data_o    (commit_data_o),
        .commit_exc_o     (commit_exc_o),
        .src_data_o       (src_data_o),
        .src_complete_o   (src_complete_o)
    );

endmodule

/* verification/rob_tb.sv */
`timescale 1ns/10ps

module rob_tb import rob_pkg::*; ();

    typedef struct packed {
        logic [ROB_WIDTH-1:0] id;
        logic [AREG_W-1:0]    areg;
        logic [PC_W-1:0]      pc;
        rob_inst_type_e       itype;
        logic                 wreg;
        logic                 done;
        logic [DATA_W-1:0]    data;
        logic [EXC_W-1:0]     exc;
    } entry_t;

    logic                                clk = 1'b0;
    logic                                rst_n_i;
    logic                                flush_i;
    logic           [1:0]                dispatch_valid_i;
    logic           [1:0][AREG_W-1:0]    dispatch_areg_i;
    logic           [1:0][PC_W-1:0]      dispatch_pc_i;
    rob_inst_type_e [1:0]                dispatch_type_i;
    logic           [1:0]                dispatch_wreg_i;
    logic           [1:0][ROB_WIDTH-1:0] dispatch_rob_id_o;
    logic                                dispatch_ready_o;
    logic           [1:0][ROB_WIDTH-1:0] src_id_i;
    logic           [1:0][DATA_W-1:0]    src_data_o;
    logic           [1:0]                src_complete_o;
    logic           [1:0]                cdb_valid_i;
    logic           [1:0][ROB_WIDTH-1:0] cdb_rob_id_i;
    logic           [1:0][DATA_W-1:0]    cdb_data_i;
    logic           [1:0][EXC_W-1:0]     cdb_exc_i;
    logic           [1:0]                commit_req_i;
    logic           [1:0]                commit_valid_o;
    logic           [1:0][AREG_W-1:0]    commit_areg_o;
    logic           [1:0][PC_W-1:0]      commit_pc_o;
    rob_inst_type_e [1:0]                commit_type_o;
    logic           [1:0]                commit_wreg_o;
    logic           [1:0][DATA_W-1:0]    commit_data_o;
    logic           [1:0][EXC_W-1:0]     commit_exc_o;

    // reference model with the oldest entry at the front
    entry_t                 rob_q[$];
    logic [ROB_WIDTH-1:0]   next_id;
    int                     src_idx [2];
    logic                   exp_ready;
    logic [1:0]             exp_valid;
    logic [1:0]             exp_src_done;
    logic [1:0][DATA_W-1:0] exp_src_data;
    logic [31:0]            lfsr_q = 32'd94100;

    always #10 clk = ~clk;

    rob_top DUT (.*);

    ////////////////////
    // helpers
    ////////////////////

    // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic string slot_name(input string base, input int k);
        return $sformatf("%s[%0d]", base, k);
    endfunction

    task automatic show_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    // in-order commit and ready while two entries are free
    function automatic void compute_expected();
        int n;
        n = rob_q.size();
        exp_ready = (n <= ROB_DEPTH - 2);
        exp_valid = 2'b00;
        if (n >= 1) begin
            exp_valid[0] = rob_q[0].done;
        end
        if (n >= 2) begin
            exp_valid[1] = exp_valid[0] & rob_q[1].done;
        end
        for (int k = 0; k < 2; k++) begin
            exp_src_done[k] = 1'b0;
            exp_src_data[k] = '0;
            if (src_idx[k] >= 0 && src_idx[k] < n) begin
                exp_src_done[k] = rob_q[src_idx[k]].done;
                exp_src_data[k] = rob_q[src_idx[k]].data;
            end
        end
    endfunction

    // apply this cycle's inputs as the DUT does on the coming edge
    task automatic update_model();
        entry_t e;
        if (flush_i) begin
            rob_q.delete();
            next_id = '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                for (int i = 0; i < rob_q.size(); i++) begin
                    if (cdb_valid_i[k] && rob_q[i].id == cdb_rob_id_i[k]) begin
                        e = rob_q[i];
                        e.done = 1'b1;
                        e.data = cdb_data_i[k];
                        e.exc  = cdb_exc_i[k];
                        rob_q[i] = e;
                    end
                end
            end
            for (int k = 0; k < 2; k++) begin
                if (commit_req_i[k] && rob_q.size() > 0) begin
                    void'(rob_q.pop_front());
                end
            end
            for (int k = 0; k < 2; k++) begin
                if (dispatch_valid_i[k]) begin
                    e = '0;
                    e.id    = next_id;
                    e.areg  = dispatch_areg_i[k];
                    e.pc    = dispatch_pc_i[k];
                    e.itype = dispatch_type_i[k];
                    e.wreg  = dispatch_wreg_i[k];
                    rob_q.push_back(e);
                    next_id = next_id + ROB_WIDTH'(1);
                end
            end
        end
    endtask

    task automatic load_cdb_slot(input int k, input int idx);
        logic [31:0] r;
        cdb_valid_i[k]  = 1'b1;
        cdb_rob_id_i[k] = rob_q[idx].id;
        cdb_data_i[k]   = take_bits(DATA_W);
        r = take_bits(3);
        // about one result in eight raises an exception
        if (r[2:0] == 3'd0) begin
            r = take_bits(EXC_W);
            cdb_exc_i[k] = r[EXC_W-1:0];
        end else begin
            cdb_exc_i[k] = '0;
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic drive_cycle(input logic hold_commit, input logic no_dispatch,
                               input logic do_flush);
        int          open_idx[$];
        int          i0;
        logic [31:0] r;
        @(posedge clk);
        #2;
        flush_i = do_flush;
        r = take_bits(1);
        dispatch_valid_i[0] = !do_flush && !no_dispatch && (rob_q.size() <= ROB_DEPTH - 2)
                              && r[0];
        r = take_bits(1);
        dispatch_valid_i[1] = dispatch_valid_i[0] && r[0];
        for (int k = 0; k < 2; k++) begin
            r = take_bits(AREG_W);
            dispatch_areg_i[k] = r[AREG_W-1:0];
            dispatch_pc_i[k] = take_bits(PC_W);
            r = take_bits(2);
            dispatch_type_i[k] = rob_inst_type_e'(r[1:0]);
            r = take_bits(1);
            dispatch_wreg_i[k] = r[0];
        end
        // results arrive in any order on at most two distinct ids
        cdb_valid_i = 2'b00;
        for (int i = 0; i < rob_q.size(); i++) begin
            if (!rob_q[i].done) begin
                open_idx.push_back(i);
            end
        end
        r = take_bits(2);
        if (!do_flush && open_idx.size() > 0 && r[0]) begin
            i0 = int'(take_bits(8)) % open_idx.size();
            load_cdb_slot(0, open_idx[i0]);
            if (open_idx.size() > 1 && r[1]) begin
                i0 = (i0 + 1 + int'(take_bits(8)) % (open_idx.size() - 1)) % open_idx.size();
                load_cdb_slot(1, open_idx[i0]);
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (rob_q.size() > 0) begin
                src_idx[k] = int'(take_bits(8)) % rob_q.size();
                src_id_i[k] = rob_q[src_idx[k]].id;
            end else begin
                src_idx[k] = -1;
                r = take_bits(ROB_WIDTH);
                src_id_i[k] = r[ROB_WIDTH-1:0];
            end
        end
        compute_expected();
        r = take_bits(2);
        commit_req_i[0] = !do_flush && !hold_commit && exp_valid[0] && r[0];
        commit_req_i[1] = commit_req_i[0] && exp_valid[1] && r[1];
    endtask

    task automatic fill_buffer();
        int cycles;
        cycles = 0;
        while (rob_q.size() <= ROB_DEPTH - 2) begin
            if (cycles == 80) begin
                stop_on_timeout("ROB did not fill while commit was held");
            end
            drive_cycle(1'b1, 1'b0, 1'b0);
            cycles++;
        end
        // stay full for a while with ready low
        repeat (6) drive_cycle(1'b1, 1'b0, 1'b0);
    endtask

    task automatic drain_buffer();
        int cycles;
        cycles = 0;
        while (rob_q.size() > 0) begin
            if (cycles == 300) begin
                stop_on_timeout("ROB did not drain");
            end
            drive_cycle(1'b0, 1'b1, 1'b0);
            cycles++;
        end
    endtask

    ////////////////////
    // checker
    ////////////////////

    always @(negedge clk) begin
        if (rst_n_i) begin
            compute_expected();
            assert (dispatch_ready_o == exp_ready)
                else show_mismatch("dispatch_ready_o", 64'(dispatch_ready_o), 64'(exp_ready));
            assert (commit_valid_o == exp_valid)
                else show_mismatch("commit_valid_o", 64'(commit_valid_o), 64'(exp_valid));
            assert (dispatch_rob_id_o[0] == next_id)
                else show_mismatch("dispatch_rob_id_o[0]", 64'(dispatch_rob_id_o[0]),
                                   64'(next_id));
            assert (dispatch_rob_id_o[1] == next_id + ROB_WIDTH'(1))
                else show_mismatch("dispatch_rob_id_o[1]", 64'(dispatch_rob_id_o[1]),
                                   64'(next_id + ROB_WIDTH'(1)));
            for (int k = 0; k < 2; k++) begin
                if (exp_valid[k]) begin
                    assert (commit_areg_o[k] == rob_q[k].areg)
                        else show_mismatch(slot_name("commit_areg_o", k),
                                           64'(commit_areg_o[k]), 64'(rob_q[k].areg));
                    assert (commit_pc_o[k] == rob_q[k].pc)
                        else show_mismatch(slot_name("commit_pc_o", k),
                                           64'(commit_pc_o[k]), 64'(rob_q[k].pc));
                    assert (commit_type_o[k] == rob_q[k].itype)
                        else show_mismatch(slot_name("commit_type_o", k),
                                           64'(commit_type_o[k]), 64'(rob_q[k].itype));
                    assert (commit_wreg_o[k] == rob_q[k].wreg)
                        else show_mismatch(slot_name("commit_wreg_o", k),
                                           64'(commit_wreg_o[k]), 64'(rob_q[k].wreg));
                    assert (commit_data_o[k] == rob_q[k].data)
                        else show_mismatch(slot_name("commit_data_o", k),
                                           64'(commit_data_o[k]), 64'(rob_q[k].data));
                    assert (commit_exc_o[k] == rob_q[k].exc)
                        else show_mismatch(slot_name("commit_exc_o", k),
                                           64'(commit_exc_o[k]), 64'(rob_q[k].exc));
                end
                if (src_idx[k] >= 0) begin
                    assert (src_complete_o[k] == exp_src_done[k])
                        else show_mismatch(slot_name("src_complete_o", k),
                                           64'(src_complete_o[k]), 64'(exp_src_done[k]));
                    if (exp_src_done[k]) begin
                        assert (src_data_o[k] == exp_src_data[k])
                            else show_mismatch(slot_name("src_data_o", k),
                                               64'(src_data_o[k]), 64'(exp_src_data[k]));
                    end
                end
            end
            update_model();
        end
    end

    initial begin
        rst_n_i            = 1'b0;
        flush_i            = 1'b0;
        dispatch_valid_i   = '0;
        dispatch_areg_i    = '0;
        dispatch_pc_i      = '0;
        dispatch_type_i[0] = INST_ALU;
        dispatch_type_i[1] = INST_ALU;
        dispatch_wreg_i    = '0;
        src_id_i           = '0;
        cdb_valid_i        = '0;
        cdb_rob_id_i       = '0;
        cdb_data_i         = '0;
        cdb_exc_i          = '0;
        commit_req_i       = '0;
        next_id            = '0;
        src_idx[0]         = -1;
        src_idx[1]         = -1;
        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        for (int c = 0; c < 400; c++) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
        end
        fill_buffer();
        drain_buffer();
        for (int c = 0; c < 150; c++) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
        end
        // flush with entries in flight so ids restart at 0
        drive_cycle(1'b0, 1'b0, 1'b1);
        for (int c = 0; c < 300; c++) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
        end
        fill_buffer();
        drain_buffer();
        repeat (3) drive_cycle(1'b1, 1'b1, 1'b0);
        @(negedge clk);
        #1;
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* tb.f */
src/rob_pkg.sv
src/rob_info_table.sv
src/rob_result_table.sv
src/rob_commit_ctrl.sv
src/rob_top.sv
verification/rob_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ROB testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module rob_tb -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vrob_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
